// File: Bender.yml
package:
  name: kernel_bridge

sources:
  - hdl/kernel_pkg.sv
  - hdl/fifo_bp.sv
  - hdl/stage_buffer.sv
  - hdl/host_ctrl.sv
  - hdl/axi_write_port.sv
  - hdl/kernel_top.sv
  - target: test
    files:
      - verification/tb_kernel.sv

// File: hdl/axi_write_port.sv
`timescale 1ns/100ps

module axi_write_port (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              aw_push,
  input  logic                              w_push,
  input  logic [kernel_pkg::STAGE_W-1:0]    stage,
  input  logic                              b_pop,
  output logic                              b_valid,
  output logic [kernel_pkg::B_ENTRY_W-1:0]  b_entry,
  output logic [kernel_pkg::AXI_ADDR_W-1:0] awaddr,
  output logic [kernel_pkg::AXI_SIZE_W-1:0] awsize,
  output logic [kernel_pkg::AXI_ID_W-1:0]   awid,
  output logic [7:0]                        awlen,
  output logic [1:0]                        awburst,
  output logic [3:0]                        awcache,
  output logic [0:0]                        awlock,
  output logic [2:0]                        awprot,
  output logic [3:0]                        awqos,
  output logic                              awvalid,
  input  logic                              awready,
  output logic [kernel_pkg::AXI_DATA_W-1:0] wdata,
  output logic [kernel_pkg::AXI_STRB_W-1:0] wstrb,
  output logic                              wlast,
  output logic                              wvalid,
  input  logic                              wready,
  input  logic [kernel_pkg::AXI_ID_W-1:0]   bid,
  input  logic [kernel_pkg::AXI_RESP_W-1:0] bresp,
  input  logic                              bvalid,
  output logic                              bready
);

  import kernel_pkg::*;

  logic [AW_ENTRY_W-1:0] aw_rdata;
  logic [W_ENTRY_W-1:0]  w_rdata;

  // a push into a full FIFO is lost
  fifo_bp #(
    .WIDTH      (AW_ENTRY_W),
    .LOG2_DEPTH (FIFO_LOG2_DEPTH)
  ) aw_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (aw_push),
    .wdata  (stage[AW_ENTRY_W-1:0]),
    .wready (),
    .rvalid (awvalid),
    .rdata  (aw_rdata),
    .rready (awready)
  );

  fifo_bp #(
    .WIDTH      (W_ENTRY_W),
    .LOG2_DEPTH (FIFO_LOG2_DEPTH)
  ) w_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (w_push),
    .wdata  (stage[W_ENTRY_W-1:0]),
    .wready (),
    .rvalid (wvalid),
    .rdata  (w_rdata),
    .rready (wready)
  );

  fifo_bp #(
    .WIDTH      (B_ENTRY_W),
    .LOG2_DEPTH (FIFO_LOG2_DEPTH)
  ) b_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (bvalid),
    .wdata  ({bid, bresp}),
    .wready (bready),
    .rvalid (b_valid),
    .rdata  (b_entry),
    .rready (b_pop)
  );

  // single-beat INCR, everything else zero
  always_comb begin
    {awsize, awaddr} = aw_rdata;
    awid    = WRITE_ID;
    awlen   = 8'd0;
    awburst = BURST_INCR;
    awcache = 4'd0;
    awlock  = 1'b0;
    awprot  = 3'd0;
    awqos   = 4'd0;
  end

  always_comb begin
    {wstrb, wdata} = w_rdata;
    wlast = 1'b1;
  end

endmodule

// File: hdl/fifo_bp.sv
`timescale 1ns/100ps

module fifo_bp #(
  parameter int WIDTH      = 32,
  parameter int LOG2_DEPTH = 4
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             wvalid,
  input  logic [WIDTH-1:0] wdata,
  output logic             wready,
  output logic             rvalid,
  output logic [WIDTH-1:0] rdata,
  input  logic             rready
);

  localparam int DEPTH = 1 << LOG2_DEPTH;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [LOG2_DEPTH-1:0] wr_ptr;
  logic [LOG2_DEPTH-1:0] rd_ptr;
  logic [LOG2_DEPTH:0]   count;
  logic                  push;
  logic                  pop;

  assign wready = (count != (LOG2_DEPTH+1)'(DEPTH)); // full drops the push
  assign rvalid = (count != '0);
  assign rdata  = mem[rd_ptr]; // show-ahead head

  assign push = wvalid && wready;
  assign pop  = rvalid && rready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/host_ctrl.sv
`timescale 1ns/100ps

module host_ctrl (
  input  logic                                       clk,
  input  logic                                       rstn,
  input  logic [kernel_pkg::HOST_ADDR_W-1:0]         host_addr,
  input  logic                                       host_en,
  input  logic [kernel_pkg::HOST_DATA_W/8-1:0]       host_we,
  input  logic [kernel_pkg::HOST_DATA_W-1:0]         host_din,
  output logic [kernel_pkg::HOST_DATA_W-1:0]         host_dout,
  output logic                                       word_we,
  output logic [$clog2(kernel_pkg::STAGE_WORDS)-1:0] word_sel,
  output logic                                       load_b,
  input  logic [kernel_pkg::HOST_DATA_W-1:0]         word_dout,
  output logic                                       aw_push,
  output logic                                       w_push,
  output logic                                       b_pop,
  input  logic                                       b_valid,
  output logic                                       ocu_rstn
);

  import kernel_pkg::*;

  localparam int SEL_W = $clog2(STAGE_WORDS);

  logic host_wr;
  logic ocu_req;
  logic is_stage;

  assign host_wr = host_en && (host_we != '0);

  // word index from the byte address
  assign word_sel = host_addr[SEL_W+1:2];

  always_comb begin
    case (host_addr)
      STAGE_W0, STAGE_W1, STAGE_W2, STAGE_W3,
      STAGE_W4, STAGE_W5, STAGE_W6, STAGE_W7: is_stage = 1'b1;
      default:                                is_stage = 1'b0;
    endcase
  end

  // the word write itself takes host_din at the strobe edge
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      word_we <= 1'b0;
      aw_push <= 1'b0;
      w_push  <= 1'b0;
      b_pop   <= 1'b0;
      ocu_req <= 1'b1;
    end else begin
      word_we <= host_wr && is_stage;
      aw_push <= host_wr && (host_addr == AW_PUSH);
      w_push  <= host_wr && (host_addr == W_PUSH);
      b_pop   <= host_wr && (host_addr == B_POP);
      if (host_wr && (host_addr == OCU_RST_CLR)) ocu_req <= 1'b0;
      if (host_wr && (host_addr == OCU_RST_SET)) ocu_req <= 1'b1;
    end
  end

  assign load_b = b_pop; // buffer takes the head as it leaves

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      host_dout <= '0;
    end else if (!host_wr) begin
      if (is_stage) begin
        host_dout <= word_dout;
      end else if (host_addr == B_STATUS) begin
        host_dout <= {{(HOST_DATA_W-1){1'b0}}, b_valid};
      end
    end
  end

  // one cycle behind the request
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ocu_rstn <= 1'b0;
    end else begin
      ocu_rstn <= ocu_req;
    end
  end

endmodule

// File: hdl/kernel_pkg.sv
package kernel_pkg;

  // host block-RAM port
  localparam int HOST_ADDR_W = 15;
  localparam int HOST_DATA_W = 32;

  localparam int STAGE_WORDS = 8;
  localparam int STAGE_W     = STAGE_WORDS * HOST_DATA_W;

  // AXI master write channel
  localparam int AXI_ADDR_W = 64;
  localparam int AXI_DATA_W = 128;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_SIZE_W = 3;
  localparam int AXI_RESP_W = 2;

  localparam int AW_ENTRY_W = AXI_SIZE_W + AXI_ADDR_W; // size, addr
  localparam int W_ENTRY_W  = AXI_STRB_W + AXI_DATA_W; // strb, data
  localparam int B_ENTRY_W  = AXI_ID_W + AXI_RESP_W;   // id, resp

  localparam int FIFO_LOG2_DEPTH = 9; // 512 entries

  localparam logic [AXI_ID_W-1:0] WRITE_ID   = 4'd1;
  localparam logic [1:0]          BURST_INCR = 2'b01;

  // host byte addresses
  typedef enum logic [HOST_ADDR_W-1:0] {
    STAGE_W0    = 15'h000,
    STAGE_W1    = 15'h004,
    STAGE_W2    = 15'h008,
    STAGE_W3    = 15'h00c,
    STAGE_W4    = 15'h010,
    STAGE_W5    = 15'h014,
    STAGE_W6    = 15'h018,
    STAGE_W7    = 15'h01c,
    AW_PUSH     = 15'h020,
    W_PUSH      = 15'h030,
    B_STATUS    = 15'h050,
    B_POP       = 15'h054,
    OCU_RST_CLR = 15'h0c0,
    OCU_RST_SET = 15'h0c4
  } host_op_e;

endpackage

// File: hdl/kernel_top.sv
`timescale 1ns/100ps

module kernel_top (
  input  logic                              clk,
  input  logic                              rstn,
  output logic                              ocu_rstn,
  input  logic [kernel_pkg::HOST_ADDR_W-1:0]   host_addr,
  input  logic                                 host_en,
  input  logic [kernel_pkg::HOST_DATA_W/8-1:0] host_we,
  input  logic [kernel_pkg::HOST_DATA_W-1:0]   host_din,
  output logic [kernel_pkg::HOST_DATA_W-1:0]   host_dout,
  output logic [kernel_pkg::AXI_ADDR_W-1:0] k2o_awaddr,
  output logic [kernel_pkg::AXI_SIZE_W-1:0] k2o_awsize,
  output logic [kernel_pkg::AXI_ID_W-1:0]   k2o_awid,
  output logic [7:0]                        k2o_awlen,
  output logic [1:0]                        k2o_awburst,
  output logic [3:0]                        k2o_awcache,
  output logic [0:0]                        k2o_awlock,
  output logic [2:0]                        k2o_awprot,
  output logic [3:0]                        k2o_awqos,
  output logic                              k2o_awvalid,
  input  logic                              k2o_awready,
  output logic [kernel_pkg::AXI_DATA_W-1:0] k2o_wdata,
  output logic [kernel_pkg::AXI_STRB_W-1:0] k2o_wstrb,
  output logic                              k2o_wlast,
  output logic                              k2o_wvalid,
  input  logic                              k2o_wready,
  input  logic [kernel_pkg::AXI_ID_W-1:0]   k2o_bid,
  input  logic [kernel_pkg::AXI_RESP_W-1:0] k2o_bresp,
  input  logic                              k2o_bvalid,
  output logic                              k2o_bready
);

  import kernel_pkg::*;

  logic                           word_we;
  logic [$clog2(STAGE_WORDS)-1:0] word_sel;
  logic                           load_b;
  logic [HOST_DATA_W-1:0]         word_dout;
  logic [STAGE_W-1:0]             stage;
  logic                           aw_push;
  logic                           w_push;
  logic                           b_pop;
  logic                           b_valid;
  logic [B_ENTRY_W-1:0]           b_entry;

  host_ctrl host_ctrl_i (
    .clk       (clk),
    .rstn      (rstn),
    .host_addr (host_addr),
    .host_en   (host_en),
    .host_we   (host_we),
    .host_din  (host_din),
    .host_dout (host_dout),
    .word_we   (word_we),
    .word_sel  (word_sel),
    .load_b    (load_b),
    .word_dout (word_dout),
    .aw_push   (aw_push),
    .w_push    (w_push),
    .b_pop     (b_pop),
    .b_valid   (b_valid),
    .ocu_rstn  (ocu_rstn)
  );

  stage_buffer stage_buffer_i (
    .clk       (clk),
    .rstn      (rstn),
    .word_we   (word_we),
    .word_sel  (word_sel),
    .word_din  (host_din), // sampled on the strobe edge
    .load_b    (load_b),
    .b_entry   (b_entry),
    .stage     (stage),
    .word_dout (word_dout)
  );

  axi_write_port axi_write_port_i (
    .clk     (clk),
    .rstn    (rstn),
    .aw_push (aw_push),
    .w_push  (w_push),
    .stage   (stage),
    .b_pop   (b_pop),
    .b_valid (b_valid),
    .b_entry (b_entry),
    .awaddr  (k2o_awaddr),
    .awsize  (k2o_awsize),
    .awid    (k2o_awid),
    .awlen   (k2o_awlen),
    .awburst (k2o_awburst),
    .awcache (k2o_awcache),
    .awlock  (k2o_awlock),
    .awprot  (k2o_awprot),
    .awqos   (k2o_awqos),
    .awvalid (k2o_awvalid),
    .awready (k2o_awready),
    .wdata   (k2o_wdata),
    .wstrb   (k2o_wstrb),
    .wlast   (k2o_wlast),
    .wvalid  (k2o_wvalid),
    .wready  (k2o_wready),
    .bid     (k2o_bid),
    .bresp   (k2o_bresp),
    .bvalid  (k2o_bvalid),
    .bready  (k2o_bready)
  );

endmodule

// File: hdl/stage_buffer.sv
`timescale 1ns/100ps

module stage_buffer (
  input  logic                                       clk,
  input  logic                                       rstn,
  input  logic                                       word_we,
  input  logic [$clog2(kernel_pkg::STAGE_WORDS)-1:0] word_sel,
  input  logic [kernel_pkg::HOST_DATA_W-1:0]         word_din,
  input  logic                                       load_b,
  input  logic [kernel_pkg::B_ENTRY_W-1:0]           b_entry,
  output logic [kernel_pkg::STAGE_W-1:0]             stage,
  output logic [kernel_pkg::HOST_DATA_W-1:0]         word_dout
);

  import kernel_pkg::*;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stage <= '0;
    end else if (load_b) begin
      stage <= STAGE_W'(b_entry); // whole buffer replaced, upper words cleared
    end else if (word_we) begin
      stage[word_sel*HOST_DATA_W +: HOST_DATA_W] <= word_din;
    end
  end

  // readback follows the selected word
  assign word_dout = stage[word_sel*HOST_DATA_W +: HOST_DATA_W];

endmodule

// File: sources.f
hdl/kernel_pkg.sv
hdl/fifo_bp.sv
hdl/stage_buffer.sv
hdl/host_ctrl.sv
hdl/axi_write_port.sv
hdl/kernel_top.sv
verification/tb_kernel.sv

// File: verification/tb_kernel.sv
`timescale 1ns/100ps

module tb_kernel;

  import kernel_pkg::*;

  localparam int HALF_PERIOD = 20;
  localparam int CLK_PERIOD  = 2 * HALF_PERIOD;
  localparam int N_BEATS     = 6;
  localparam int DRAIN_LIMIT = 100; // cycles to wait for the slave to take all beats
  // test lengths in cycles: reset, readback, address, data, responses, ocu
  localparam int TEST_CYCLES = 10 + 60 + 180 + 220 + 120 + 20;
  localparam int MARGIN      = 4;

  logic                     clk;
  logic                     rstn;
  logic                     ocu_rstn;
  logic [HOST_ADDR_W-1:0]   host_addr;
  logic                     host_en;
  logic [HOST_DATA_W/8-1:0] host_we;
  logic [HOST_DATA_W-1:0]   host_din;
  logic [HOST_DATA_W-1:0]   host_dout;
  logic [AXI_ADDR_W-1:0]    k2o_awaddr;
  logic [AXI_SIZE_W-1:0]    k2o_awsize;
  logic [AXI_ID_W-1:0]      k2o_awid;
  logic [7:0]               k2o_awlen;
  logic [1:0]               k2o_awburst;
  logic [3:0]               k2o_awcache;
  logic [0:0]               k2o_awlock;
  logic [2:0]               k2o_awprot;
  logic [3:0]               k2o_awqos;
  logic                     k2o_awvalid;
  logic                     k2o_awready;
  logic [AXI_DATA_W-1:0]    k2o_wdata;
  logic [AXI_STRB_W-1:0]    k2o_wstrb;
  logic                     k2o_wlast;
  logic                     k2o_wvalid;
  logic                     k2o_wready;
  logic [AXI_ID_W-1:0]      k2o_bid;
  logic [AXI_RESP_W-1:0]    k2o_bresp;
  logic                     k2o_bvalid;
  logic                     k2o_bready;

  logic [AW_ENTRY_W-1:0] exp_aw [$];
  logic [W_ENTRY_W-1:0]  exp_w [$];
  logic [31:0]           ready_lfsr = 32'h52d9;
  logic [31:0]           data_lfsr  = 32'h52d9;
  string                 cur_test   = "reset";
  int                    error_count;
  int                    test_err_base;
  int                    tests_run;
  int                    tests_failed;
  logic                  host_wr;

  kernel_top dut_i (.*);

  always #HALF_PERIOD clk = ~clk;

  assign host_wr = host_en && (host_we != '0);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  task automatic random_word(output logic [31:0] w);
    for (int b = 0; b < 32; b++) begin
      data_lfsr = lfsr_step(data_lfsr);
      w = {w[30:0], data_lfsr[0]};
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s (test %s)", msg, cur_test);
    error_count++;
  endtask

  task automatic compare(input string what, input logic [255:0] exp, input logic [255:0] act);
    assert (act === exp) else begin
      $display("ERR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      error_count++;
    end
  endtask

  // write edge, then one more cycle with address and data held for the strobe
  task automatic write_host(input logic [HOST_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    host_addr <= addr;
    host_din  <= data;
    host_en   <= 1'b1;
    host_we   <= 4'hf;
    @(posedge clk);
    host_en   <= 1'b0;
    host_we   <= '0;
    @(posedge clk);
  endtask

  task automatic read_host(input logic [HOST_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    host_addr <= addr;
    host_en   <= 1'b1;
    host_we   <= '0;
    @(posedge clk);
    @(negedge clk);
    data = host_dout;
  endtask

  task automatic send_response(input logic [AXI_ID_W-1:0] id, input logic [AXI_RESP_W-1:0] resp);
    @(posedge clk);
    k2o_bvalid <= 1'b1;
    k2o_bid    <= id;
    k2o_bresp  <= resp;
    @(negedge clk);
    compare("bready", 1, k2o_bready);
    @(posedge clk);
    k2o_bvalid <= 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_aw.size() != 0 || exp_w.size() != 0) && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_aw.size() != 0 || exp_w.size() != 0) begin
      report_failure("slave did not receive all pushed beats in time");
    end
  endtask

  task automatic end_test();
    int errs;
    errs = error_count - test_err_base;
    $display("test %-10s %s, %0d errors", cur_test, (errs == 0) ? "ok" : "FAILED", errs);
    tests_run++;
    if (errs != 0) tests_failed++;
    test_err_base = error_count;
  endtask

  // AXI slave model with random ready
  always @(posedge clk) begin
    if (rstn && k2o_awvalid && k2o_awready) begin
      if (exp_aw.size() == 0) begin
        report_failure("AW beat arrived with nothing pushed");
      end else begin
        compare("awaddr", exp_aw[0][AXI_ADDR_W-1:0], k2o_awaddr);
        compare("awsize", exp_aw[0][AW_ENTRY_W-1:AXI_ADDR_W], k2o_awsize);
        void'(exp_aw.pop_front());
      end
      compare("awid", 1, k2o_awid);
      compare("awburst", 1, k2o_awburst);
      compare("aw fixed", 0, {k2o_awlen, k2o_awcache, k2o_awlock, k2o_awprot, k2o_awqos});
    end
    if (rstn && k2o_wvalid && k2o_wready) begin
      if (exp_w.size() == 0) begin
        report_failure("W beat arrived with nothing pushed");
      end else begin
        compare("wdata", exp_w[0][AXI_DATA_W-1:0], k2o_wdata);
        compare("wstrb", exp_w[0][W_ENTRY_W-1:AXI_DATA_W], k2o_wstrb);
        void'(exp_w.pop_front());
      end
      compare("wlast", 1, k2o_wlast);
    end
    ready_lfsr = lfsr_step(ready_lfsr);
    k2o_awready <= ready_lfsr[0];
    ready_lfsr = lfsr_step(ready_lfsr);
    k2o_wready <= ready_lfsr[0];
  end

  assert property (@(posedge clk) disable iff (!rstn)
    host_wr && host_addr == AW_PUSH && !k2o_awvalid |-> ##1 !k2o_awvalid ##1 k2o_awvalid)
    else report_failure("awvalid did not rise two cycles after AW_PUSH");
  assert property (@(posedge clk) disable iff (!rstn)
    host_wr && host_addr == W_PUSH && !k2o_wvalid |-> ##1 !k2o_wvalid ##1 k2o_wvalid)
    else report_failure("wvalid did not rise two cycles after W_PUSH");
  assert property (@(posedge clk) disable iff (!rstn)
    k2o_awvalid && !k2o_awready |=> k2o_awvalid && $stable({k2o_awsize, k2o_awaddr}))
    else report_failure("AW beat changed or dropped under back-pressure");
  assert property (@(posedge clk) disable iff (!rstn)
    k2o_wvalid && !k2o_wready |=> k2o_wvalid && $stable({k2o_wstrb, k2o_wdata}))
    else report_failure("W beat changed or dropped under back-pressure");
  assert property (@(posedge clk) disable iff (!rstn)
    host_wr && host_addr == OCU_RST_CLR |-> ##2 !ocu_rstn)
    else report_failure("ocu_rstn not low two cycles after OCU_RST_CLR");
  assert property (@(posedge clk) disable iff (!rstn)
    host_wr && host_addr == OCU_RST_SET |-> ##2 ocu_rstn)
    else report_failure("ocu_rstn not high two cycles after OCU_RST_SET");

  initial begin
    logic [31:0]           words [8];
    logic [31:0]           rd;
    logic [AXI_ID_W-1:0]   ids [3];
    logic [AXI_RESP_W-1:0] resps [3];
    clk         = 1'b0;
    rstn        = 1'b0;
    host_addr   = '0;
    host_en     = 1'b0;
    host_we     = '0;
    host_din    = '0;
    k2o_awready = 1'b0;
    k2o_wready  = 1'b0;
    k2o_bid     = '0;
    k2o_bresp   = '0;
    k2o_bvalid  = 1'b0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    compare("awvalid", 0, k2o_awvalid);
    compare("wvalid", 0, k2o_wvalid);
    compare("ocu_rstn", 0, ocu_rstn);
    @(negedge clk);
    compare("ocu_rstn", 1, ocu_rstn); // request comes out of reset high
    end_test();

    cur_test = "readback";
    for (int i = 0; i < STAGE_WORDS; i++) begin
      random_word(words[i]);
      write_host(HOST_ADDR_W'(i * 4), words[i]);
    end
    for (int i = 0; i < STAGE_WORDS; i++) begin
      read_host(HOST_ADDR_W'(i * 4), rd);
      compare($sformatf("word %0d", i), words[i], rd);
    end
    read_host(B_STATUS, rd);
    compare("b_status", 0, rd);
    end_test();

    cur_test = "address";
    for (int n = 0; n < N_BEATS; n++) begin
      for (int i = 0; i < 3; i++) begin
        random_word(words[i]);
        write_host(HOST_ADDR_W'(i * 4), words[i]);
      end
      exp_aw.push_back({words[2][2:0], words[1], words[0]});
      write_host(AW_PUSH, 32'h0);
    end
    wait_drained();
    end_test();

    cur_test = "data";
    for (int n = 0; n < N_BEATS; n++) begin
      for (int i = 0; i < 5; i++) begin
        random_word(words[i]);
        write_host(HOST_ADDR_W'(i * 4), words[i]);
      end
      exp_w.push_back({words[4][15:0], words[3], words[2], words[1], words[0]});
      write_host(W_PUSH, 32'h0);
    end
    wait_drained();
    end_test();

    cur_test = "responses";
    for (int k = 0; k < 3; k++) begin
      ids[k]   = AXI_ID_W'(k * 5 + 3);
      resps[k] = AXI_RESP_W'(k + 1);
      send_response(ids[k], resps[k]);
    end
    read_host(B_STATUS, rd);
    compare("b_status", 1, rd);
    for (int k = 0; k < 3; k++) begin
      write_host(B_POP, 32'h0);
      read_host(STAGE_W0, rd);
      compare("popped entry", {ids[k], resps[k]}, rd);
      for (int i = 1; i < STAGE_WORDS; i++) begin
        read_host(HOST_ADDR_W'(i * 4), rd);
        compare($sformatf("cleared word %0d", i), 0, rd);
      end
    end
    read_host(B_STATUS, rd);
    compare("b_status", 0, rd);
    end_test();

    cur_test = "ocu_reset";
    write_host(OCU_RST_CLR, 32'h0);
    @(negedge clk);
    compare("ocu_rstn", 0, ocu_rstn);
    write_host(OCU_RST_SET, 32'h0);
    @(negedge clk);
    compare("ocu_rstn", 1, ocu_rstn);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * MARGIN * CLK_PERIOD);
    $display("watchdog expired before the tests finished (test %s)", cur_test);
    $display("Checks failed");
    $finish;
  end

endmodule
